// ==== common/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Reset PC, must be word aligned
`define START_ADDR 32'h0000_0000

// Data path and address width
`define XLEN 32

// Architectural registers x0..x31
`define REG_COUNT 32

// Register mirrored on the status output
`define STAT_REG 3

`endif

// ==== common/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    // Request from core to bridge, held until the matching response
    typedef struct packed {
        logic             rden;
        logic             wren;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

    // One cycle valid pulse, also ends writes
    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    // Branch offset bits are scattered over the word
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

endpackage

// ==== core/alu.sv ====
`timescale 1ns/1ns

module alu import rv_pkg::*; (
    input  alu_op_t     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] y,
    output logic        eq
);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            // Signed compare
            ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLL: y = a << b[4:0];
            ALU_SRL: y = a >> b[4:0];
        endcase
    end

    // Branch condition for BEQ and BNE
    assign eq = (a == b);

endmodule

// ==== core/reg_file.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module reg_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        we,
    input  logic [4:0]  rd_addr,
    input  logic [31:0] rd_data,
    output logic [31:0] stat
);

    logic [31:0] regs [`REG_COUNT];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            // x0 stays zero
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];
    assign stat     = regs[`STAT_REG];

endmodule

// ==== core/core.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module core import rv_pkg::*; #(
    parameter logic [31:0] START_ADDR = `START_ADDR
) (
    input  logic        clk,
    input  logic        arst_n,
    output mem_req_t    inst_req,
    input  mem_rsp_t    inst_rsp,
    output mem_req_t    data_req,
    input  mem_rsp_t    data_rsp,
    output logic [31:0] stat
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;

    typedef enum logic [1:0] {FETCH, EXEC, MEM, WB} state_t;

    state_t      state;
    logic [31:0] pc;
    logic        fetch_q;
    inst_u       inst_q;
    logic        data_rden_q;
    logic        data_wren_q;
    logic [31:0] data_addr_q;
    logic [31:0] data_wdata_q;
    logic [31:0] load_q;

    logic [31:0] rs1_data, rs2_data, rd_data;
    logic [31:0] imm_i, imm_s, imm_b, imm_j, imm_u;
    logic [31:0] alu_b, alu_y, exec_y, pc_plus4, pc_exec;
    logic        alu_eq, arith_ok, exec_we, rf_we;
    alu_op_t     alu_op, arith_op;

    assign imm_i = {{20{inst_q.i.imm[11]}}, inst_q.i.imm};
    assign imm_s = {{20{inst_q.s.imm_hi[6]}}, inst_q.s.imm_hi, inst_q.s.imm_lo};
    assign imm_b = {{20{inst_q.b.imm12}}, inst_q.b.imm11, inst_q.b.imm10_5,
                    inst_q.b.imm4_1, 1'b0};
    assign imm_j = {{12{inst_q.j.imm20}}, inst_q.j.imm19_12, inst_q.j.imm11,
                    inst_q.j.imm10_1, 1'b0};
    assign imm_u = {inst_q.u.imm, 12'd0};

    assign pc_plus4 = pc + 32'd4;

    // Register and immediate ALU ops share the funct3 map
    always_comb begin
        arith_op = ALU_ADD;
        arith_ok = 1'b1;
        case (inst_q.r.funct3)
            3'b000: begin
                if (inst_q.r.opcode == OP_OP && inst_q.r.funct7[5]) begin
                    arith_op = ALU_SUB;
                end
            end
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = ALU_SRL;
            3'b110: arith_op = ALU_OR;
            3'b111: arith_op = ALU_AND;
            default: arith_ok = 1'b0;
        endcase
    end

    // ALU operand select
    always_comb begin
        alu_op = ALU_ADD;
        alu_b  = rs2_data;
        case (inst_q.r.opcode)
            OP_IMM: begin
                alu_op = arith_op;
                alu_b  = imm_i;
            end
            OP_OP:    alu_op = arith_op;
            OP_LOAD:  alu_b = imm_i;
            OP_STORE: alu_b = imm_s;
            default: ;
        endcase
    end

    // Result, register write and next PC in EXEC
    always_comb begin
        exec_we = 1'b0;
        exec_y  = alu_y;
        pc_exec = pc_plus4;
        case (inst_q.r.opcode)
            OP_LUI: begin
                exec_we = 1'b1;
                exec_y  = imm_u;
            end
            OP_JAL: begin
                exec_we = 1'b1;
                exec_y  = pc_plus4;
                pc_exec = pc + imm_j;
            end
            OP_IMM, OP_OP: exec_we = arith_ok;
            OP_BRANCH: begin
                if ((inst_q.b.funct3 == 3'b000 && alu_eq) ||
                    (inst_q.b.funct3 == 3'b001 && !alu_eq)) begin
                    pc_exec = pc + imm_b;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= FETCH;
            pc          <= START_ADDR;
            fetch_q     <= 1'b0;
            data_rden_q <= 1'b0;
            data_wren_q <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (inst_rsp.valid) begin
                        fetch_q <= 1'b0;
                        state   <= EXEC;
                    end else begin
                        fetch_q <= 1'b1;
                    end
                end
                EXEC: begin
                    if (inst_q.r.opcode == OP_LOAD) begin
                        data_rden_q <= 1'b1;
                        state       <= MEM;
                    end else if (inst_q.r.opcode == OP_STORE) begin
                        data_wren_q <= 1'b1;
                        state       <= MEM;
                    end else begin
                        pc      <= pc_exec;
                        fetch_q <= 1'b1;
                        state   <= FETCH;
                    end
                end
                MEM: begin
                    if (data_rsp.valid) begin
                        data_rden_q <= 1'b0;
                        data_wren_q <= 1'b0;
                        if (data_rden_q) begin
                            state <= WB;
                        end else begin
                            // Store retires here
                            pc      <= pc_plus4;
                            fetch_q <= 1'b1;
                            state   <= FETCH;
                        end
                    end
                end
                WB: begin
                    pc      <= pc_plus4;
                    fetch_q <= 1'b1;
                    state   <= FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && inst_rsp.valid) begin
            inst_q <= inst_rsp.rdata;
        end
        if (state == EXEC) begin
            data_addr_q  <= alu_y;
            data_wdata_q <= rs2_data;
        end
        if (state == MEM && data_rsp.valid) begin
            load_q <= data_rsp.rdata;
        end
    end

    assign rf_we   = (state == EXEC && exec_we) || (state == WB);
    assign rd_data = (state == WB) ? load_q : exec_y;

    assign inst_req = '{rden: fetch_q, wren: 1'b0, addr: pc, wdata: 32'd0};
    assign data_req = '{rden: data_rden_q, wren: data_wren_q,
                        addr: data_addr_q, wdata: data_wdata_q};

    reg_file i_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (inst_q.r.rs1),
        .rs2_addr (inst_q.r.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd_addr  (inst_q.r.rd),
        .rd_data  (rd_data),
        .stat     (stat)
    );

    alu i_alu (
        .op (alu_op),
        .a  (rs1_data),
        .b  (alu_b),
        .y  (alu_y),
        .eq (alu_eq)
    );

endmodule

// ==== mmu/mmu_axi.sv ====
`timescale 1ns/1ns

module mmu_axi import rv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  mem_req_t    inst_req,
    output mem_rsp_t    inst_rsp,
    input  mem_req_t    data_req,
    output mem_rsp_t    data_rsp,

    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    output logic        rready,

    output logic [31:0] awaddr,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    typedef enum logic [1:0] {IDLE, READ, WRITE} state_t;

    state_t      state;
    logic        serve_data;
    logic        rsp_pulse;
    logic [31:0] rdata_q;
    logic        start_data;
    logic        start_inst;

    // Requester still sees its response this cycle, so hold off
    assign start_data = (state == IDLE) && !rsp_pulse && (data_req.rden || data_req.wren);
    assign start_inst = (state == IDLE) && !rsp_pulse && !start_data && inst_req.rden;

    // Address phase must be done before taking the response
    assign rready = (state == READ) && !arvalid;
    assign bready = (state == WRITE) && !awvalid && !wvalid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            serve_data <= 1'b0;
            rsp_pulse  <= 1'b0;
            arvalid    <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
        end else begin
            rsp_pulse <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_data) begin
                        serve_data <= 1'b1;
                        if (data_req.wren) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            state   <= WRITE;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= READ;
                        end
                    end else if (start_inst) begin
                        serve_data <= 1'b0;
                        arvalid    <= 1'b1;
                        state      <= READ;
                    end
                end
                READ: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid && rready) begin
                        rsp_pulse <= 1'b1;
                        state     <= IDLE;
                    end
                end
                WRITE: begin
                    // AW and W complete independently
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if (bvalid && bready) begin
                        rsp_pulse <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_data) begin
            araddr <= data_req.addr;
            awaddr <= data_req.addr;
            wdata  <= data_req.wdata;
        end else if (start_inst) begin
            araddr <= inst_req.addr;
        end
        if (rvalid && rready) begin
            rdata_q <= rdata;
        end
    end

    assign inst_rsp = '{valid: rsp_pulse && !serve_data, rdata: rdata_q};
    assign data_rsp = '{valid: rsp_pulse && serve_data, rdata: rdata_q};

endmodule

// ==== logic/sasanqua.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module sasanqua import rv_pkg::*; #(
    parameter logic [31:0] START_ADDR = `START_ADDR
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic [31:0] stat,

    output logic [31:0] araddr,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    output logic        rready,

    output logic [31:0] awaddr,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    mem_req_t inst_req, data_req;
    mem_rsp_t inst_rsp, data_rsp;

    core #(
        .START_ADDR (START_ADDR)
    ) i_core (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst_req (inst_req),
        .inst_rsp (inst_rsp),
        .data_req (data_req),
        .data_rsp (data_rsp),
        .stat     (stat)
    );

    mmu_axi i_mmu_axi (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst_req (inst_req),
        .inst_rsp (inst_rsp),
        .data_req (data_req),
        .data_rsp (data_rsp),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rready   (rready),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

endmodule

// ==== dv/sasanqua_props.sv ====
`timescale 1ns/1ns

module sasanqua_props (
    input logic        clk,
    input logic        arst_n,
    input logic [31:0] araddr,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] awaddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata,
    input logic        wvalid,
    input logic        wready
);

    // Valid and payload held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR valid dropped or address changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW valid dropped or address changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W valid dropped or data changed before wready");

    // One transfer at a time
    ar_aw_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(arvalid && awvalid))
        else $error("AR and AW valid high together");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !arvalid && !awvalid && !wvalid)
        else $error("Bus valid high during reset");

endmodule

bind mmu_axi sasanqua_props i_sasanqua_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wready  (wready)
);

// ==== dv/sasanqua_tb.sv ====
`timescale 1ns/1ns
`include "rv_consts.svh"

module sasanqua_tb;

    localparam int N_TESTS      = 6;
    localparam int PROG_LEN     = 16;
    localparam int MEM_WORDS    = 256;
    localparam int DONE_ADDR    = 'h3fc;
    localparam int CHK_ADDR     = 'h200;
    localparam int RESET_CYCLES = 4;
    localparam int TIMEOUT      = 2000;
    localparam int DRAIN_CYCLES = 30;
    localparam int SEED         = 85843;

    localparam int F3_ADD = 0;
    localparam int F3_SLL = 1;
    localparam int F3_SLT = 2;
    localparam int F3_XOR = 4;
    localparam int F3_SRL = 5;
    localparam int F3_OR  = 6;
    localparam int F3_AND = 7;

    logic        clk;
    logic        arst_n = 1'b0;
    logic [31:0] stat;
    logic [31:0] araddr, awaddr, wdata;
    logic        arvalid, rready, awvalid, wvalid, bready;
    logic        arready = 1'b0;
    logic        rvalid  = 1'b0;
    logic        awready = 1'b0;
    logic        wready  = 1'b0;
    logic        bvalid  = 1'b0;
    logic [31:0] rdata   = '0;

    // Slave memory and the image copied into it during reset
    logic [31:0] mem [MEM_WORDS];
    logic [31:0] img [MEM_WORDS];

    bit          ar_hs, r_hs, aw_hs, w_hs, b_hs, aw_got, w_got, ar_seen, timed_out;
    bit          in_rst;
    logic [31:0] ar_a, aw_a, w_d, aw_q, w_q, first_ar;
    int          ar_wait, aw_wait, w_wait, done_cnt;

    // Program table
    logic [31:0] prog     [N_TESTS][PROG_LEN];
    int          prog_len [N_TESTS];
    logic [31:0] exp_stat [N_TESTS];
    logic [31:0] exp_mem  [N_TESTS];
    string       name     [N_TESTS];
    int          cur, errors, errs_before, passed;

    sasanqua i_sasanqua (
        .clk     (clk),
        .arst_n  (arst_n),
        .stat    (stat),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // AXI slave, samples at the edge and drives 1 ns later
    always @(posedge clk) begin
        in_rst = !arst_n;
        ar_hs  = arvalid && arready;
        r_hs   = rvalid && rready;
        aw_hs  = awvalid && awready;
        w_hs   = wvalid && wready;
        b_hs   = bvalid && bready;
        ar_a   = araddr;
        aw_a   = awaddr;
        w_d    = wdata;
        #1;
        if (in_rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] = img[i];
            end
            {arready, rvalid, awready, wready, bvalid} = '0;
            {aw_got, w_got, ar_seen} = '0;
            ar_wait  = $urandom % 4;
            aw_wait  = $urandom % 4;
            w_wait   = $urandom % 4;
            done_cnt = 0;
        end else begin
            if (r_hs) begin
                rvalid = 1'b0;
            end
            if (ar_hs) begin
                if (!ar_seen) begin
                    first_ar = ar_a;
                    ar_seen  = 1'b1;
                end
                arready = 1'b0;
                ar_wait = $urandom % 4;
                rdata   = mem[ar_a[9:2]];
                rvalid  = 1'b1;
            end else if (arvalid && !arready) begin
                if (ar_wait == 0) arready = 1'b1;
                else ar_wait--;
            end
            if (b_hs) begin
                bvalid = 1'b0;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end
            if (aw_hs) begin
                awready = 1'b0;
                aw_got  = 1'b1;
                aw_q    = aw_a;
                aw_wait = $urandom % 4;
            end else if (awvalid && !awready) begin
                if (aw_wait == 0) awready = 1'b1;
                else aw_wait--;
            end
            if (w_hs) begin
                wready = 1'b0;
                w_got  = 1'b1;
                w_q    = w_d;
                w_wait = $urandom % 4;
            end else if (wvalid && !wready) begin
                if (w_wait == 0) wready = 1'b1;
                else w_wait--;
            end
            // Both halves in, commit and answer on B
            if (aw_got && w_got && !bvalid) begin
                mem[aw_q[9:2]] = w_q;
                bvalid = 1'b1;
                if (aw_q == DONE_ADDR) done_cnt++;
            end
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return ~a ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] alu_i(input int f3, input int rd, input int rs1,
                                          input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_r(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] load_w(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] store_w(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_word(input logic [31:0] w);
        prog[cur][prog_len[cur]] = w;
        prog_len[cur]++;
    endtask

    // Every program stores x3 to the done address, then spins
    task automatic close_prog(input string n, input logic [31:0] st, input logic [31:0] em);
        add_word(store_w(3, 0, DONE_ADDR));
        add_word(jal(0, 0));
        name[cur]     = n;
        exp_stat[cur] = st;
        exp_mem[cur]  = em;
        cur++;
    endtask

    task automatic build_table();
        cur = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            prog_len[t] = 0;
        end
        add_word(lui(1, 'h12345));
        add_word(alu_i(F3_ADD, 1, 1, 'h678));
        add_word(alu_i(F3_AND, 2, 1, 'h0f0));
        add_word(alu_i(F3_OR, 2, 2, 'h503));
        add_word(alu_i(F3_XOR, 3, 2, -1));
        add_word(alu_i(F3_SLT, 4, 3, 0));
        add_word(alu_r(0, F3_ADD, 3, 3, 4));
        close_prog("immediates", (((32'h1234_5678 & 32'h0f0) | 32'h503) ^ 32'hffff_ffff) + 32'd1,
                   fill_word(CHK_ADDR));
        add_word(alu_i(F3_ADD, 1, 0, 100));
        add_word(alu_i(F3_ADD, 2, 0, -7));
        add_word(alu_r('h20, F3_ADD, 3, 1, 2));
        add_word(alu_r(0, F3_SLT, 4, 2, 1));
        add_word(alu_r(0, F3_SLL, 5, 1, 4));
        add_word(alu_i(F3_ADD, 6, 0, 3));
        add_word(alu_r(0, F3_SRL, 7, 2, 6));
        add_word(alu_r(0, F3_XOR, 8, 5, 7));
        add_word(alu_r(0, F3_AND, 9, 8, 1));
        add_word(alu_r(0, F3_OR, 3, 3, 9));
        add_word(alu_r(0, F3_ADD, 3, 3, 4));
        close_prog("register ops",
                   ((32'd107) | (((32'd100 << 1) ^ (32'hffff_fff9 >> 3)) & 32'd100)) + 32'd1,
                   fill_word(CHK_ADDR));
        add_word(alu_i(F3_ADD, 3, 0, 9));
        add_word(alu_i(F3_ADD, 0, 0, 55));
        add_word(alu_r(0, F3_ADD, 3, 0, 0));
        close_prog("x0 stays zero", 32'd0, fill_word(CHK_ADDR));
        add_word(alu_i(F3_ADD, 1, 0, 'h5a5));
        add_word(lui(2, 'hcafe0));
        add_word(alu_r(0, F3_OR, 2, 2, 1));
        add_word(store_w(2, 0, CHK_ADDR));
        add_word(load_w(5, 0, CHK_ADDR));
        add_word(alu_r(0, F3_ADD, 3, 5, 1));
        close_prog("load store", 32'hcafe_05a5 + 32'h5a5, 32'hcafe_05a5);
        // Taken branches skip +1, +8 and +16
        add_word(alu_i(F3_ADD, 1, 0, 5));
        add_word(alu_i(F3_ADD, 2, 0, 5));
        add_word(branch(0, 1, 2, 8));
        add_word(alu_i(F3_ADD, 3, 3, 1));
        add_word(branch(1, 1, 2, 8));
        add_word(alu_i(F3_ADD, 3, 3, 2));
        add_word(branch(0, 1, 0, 8));
        add_word(alu_i(F3_ADD, 3, 3, 4));
        add_word(branch(1, 1, 0, 8));
        add_word(alu_i(F3_ADD, 3, 3, 8));
        add_word(jal(4, 8));
        add_word(alu_i(F3_ADD, 3, 3, 16));
        add_word(alu_r(0, F3_ADD, 3, 3, 4));
        close_prog("branches", 32'd2 + 32'd4 + (32'd40 + 32'd4), fill_word(CHK_ADDR));
        add_word(alu_i(F3_ADD, 3, 0, 7));
        add_word(32'h0000_018b);
        add_word(store_w(3, 0, CHK_ADDR) ^ 32'h08);
        add_word(alu_i(F3_ADD, 3, 3, 1));
        close_prog("unknown opcode", 32'd8, fill_word(CHK_ADDR));
    endtask

    task automatic load_image(input int t);
        for (int i = 0; i < MEM_WORDS; i++) begin
            img[i] = fill_word(i * 4);
        end
        for (int k = 0; k < prog_len[t]; k++) begin
            img[k] = prog[t][k];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic wait_done(output bit expired);
        int cycles;
        cycles = 0;
        while (done_cnt == 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        expired = (done_cnt == 0);
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    initial begin
        errors = 0;
        passed = 0;
        void'($urandom(SEED));
        build_table();
        for (int t = 0; t < N_TESTS; t++) begin
            errs_before = errors;
            load_image(t);
            apply_reset();
            wait_done(timed_out);
            if (timed_out) begin
                $display("test %0d %s: no store to the done address arrived within %0d cycles",
                         t, name[t], TIMEOUT);
                errors++;
            end else begin
                // Let the spin loop run to catch a repeated done store
                repeat (DRAIN_CYCLES) @(posedge clk);
                #1;
                check_word("stat", stat, exp_stat[t]);
                check_word("check word", mem[CHK_ADDR / 4], exp_mem[t]);
                check_word("done word", mem[DONE_ADDR / 4], exp_stat[t]);
                check_word("done store count", done_cnt, 32'd1);
                check_word("first fetch address", first_ar, `START_ADDR);
            end
            if (errors == errs_before) begin
                passed++;
                $display("test %0d %s: ok", t, name[t]);
            end else begin
                $display("test %0d %s: failed", t, name[t]);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 N_TESTS, passed, N_TESTS - passed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+common
common/rv_pkg.sv
core/alu.sv
core/reg_file.sv
core/core.sv
mmu/mmu_axi.sv
logic/sasanqua.sv
dv/sasanqua_props.sv
dv/sasanqua_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := sasanqua_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
